// ==== source/pm_cfg_pkg.sv ====
// Configuration defaults for the power-control subsystem
// These values only seed the parameters of pm_top
// Every lower module gets its sizes passed down from there
package pm_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt side
  ////////////////////////////////////////////////////////////////////////////

  // Number of interrupt lines that can wake the core
  // Each line has its own enable bit in irq_enable_i
  localparam int PM_NUM_IRQ = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Statistics side
  ////////////////////////////////////////////////////////////////////////////

  // Width of the sleep cycle counter and the sleep entry counter
  // Both counters saturate at the all-ones value of this width
  // Eight bits keep a long sleep within a short simulation
  localparam int PM_STAT_WIDTH = 8;

  // Software reads the counters as plain levels
  // so no bus width is defined here

endpackage

// ==== source/pm_status_pkg.sv ====
// Status encodings shared by the wake detector and the statistics block
// The testbench also uses these to decode last_wake_cause_o
package pm_status_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Wake cause
  ////////////////////////////////////////////////////////////////////////////

  // Reason that the core left sleep
  // Debug has priority over interrupts when both are present
  // The code 3 is unused and never produced
  typedef enum logic [1:0] {
    WAKE_NONE  = 2'd0,
    WAKE_IRQ   = 2'd1,
    WAKE_DEBUG = 2'd2
  } wake_cause_e;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // Number of flops between an interrupt pin and the wake level
  // An enabled interrupt therefore reaches the wake level this many
  // clock edges after it rises, and leaves it as many edges after it drops
  localparam int PM_SYNC_STAGES = 2;

  // The debug request is already synchronous to the core clock
  // and bypasses the synchronizer entirely

endpackage

// ==== source/pm_wake_detect.sv ====
module pm_wake_detect #(
  parameter int NUM_IRQ = pm_cfg_pkg::PM_NUM_IRQ
) (
  // Free running clock and asynchronous reset
  input  logic                       clk_ungated_i,
  input  logic                       rst_n,

  // Raw interrupt lines and their enables
  input  logic [NUM_IRQ-1:0]         irq_i,
  input  logic [NUM_IRQ-1:0]         irq_enable_i,

  // Debug request, already synchronous
  input  logic                       debug_req_i,

  // Wake level and the reason for it
  output logic                       wake_o,
  output pm_status_pkg::wake_cause_e wake_cause_o
);

  import pm_status_pkg::*;

  // Synchronizer chain, one vector per stage
  // Stage 0 samples the pins and the last stage feeds the mask
  logic [NUM_IRQ-1:0] irq_sync_q [PM_SYNC_STAGES];

  // Synchronized lines after the enable mask
  logic [NUM_IRQ-1:0] irq_masked;

  // At least one enabled and synchronized line is high
  logic               irq_pending;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // The interrupt pins come from other clock domains
  // Each line gets its own flop chain so the wake level never sees a
  // metastable value
  always_ff @(posedge clk_ungated_i, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PM_SYNC_STAGES; i++) begin
        irq_sync_q[i] <= '0;
      end
    end else begin
      irq_sync_q[0] <= irq_i;
      for (int i = 1; i < PM_SYNC_STAGES; i++) begin
        irq_sync_q[i] <= irq_sync_q[i-1];
      end
    end
  end

  // The enables come from a register in the core clock domain
  // and are applied after the synchronizer, so masking takes effect at once
  assign irq_masked  = irq_sync_q[PM_SYNC_STAGES-1] & irq_enable_i;

  // Any enabled line is enough to wake
  assign irq_pending = |irq_masked;

  ////////////////////////////////////////////////////////////////////////////
  // Wake level and cause
  ////////////////////////////////////////////////////////////////////////////

  // Debug wakes in the same cycle because it needs no synchronizer
  assign wake_o = irq_pending | debug_req_i;

  // Fixed priority with debug first, then interrupts
  // The cause follows the wake level and is WAKE_NONE while it is low
  always_comb begin
    if (debug_req_i) begin
      wake_cause_o = WAKE_DEBUG;
    end else if (irq_pending) begin
      wake_cause_o = WAKE_IRQ;
    end else begin
      wake_cause_o = WAKE_NONE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // A line held high with its enable set must reach the wake level
  // once it has passed the whole synchronizer
  a_irq_reaches_wake : assert property (
    @(posedge clk_ungated_i) disable iff (!rst_n)
    ((irq_i & irq_enable_i) != '0) ##PM_SYNC_STAGES
    ((irq_i & irq_enable_i & $past(irq_i, PM_SYNC_STAGES)) != '0) |-> wake_o
  );

endmodule

// ==== source/pm_clock_gate.sv ====
module pm_clock_gate (
  // Free running clock
  input  logic clk_i,
  // Functional enable and scan override
  input  logic en_i,
  input  logic scan_cg_en_i,
  // Gated clock
  output logic clk_o
);

  // Enable as seen through the latch
  logic en_latched;

  // The latch is open only while the clock is low
  // An enable change during the high phase waits for the next low phase,
  // so the output never shows a shortened pulse
  always_latch begin
    if (!clk_i) begin
      en_latched = en_i | scan_cg_en_i;
    end
  end

  // The AND passes whole high phases only
  // With the latch closed during the high phase the enable is stable here
  assign clk_o = clk_i & en_latched;

endmodule

// ==== source/pm_sleep_unit.sv ====
module pm_sleep_unit (
  // Free running clock and asynchronous reset
  input  logic clk_ungated_i,
  input  logic rst_n,

  // Forces the clock gate open during scan test
  input  logic scan_cg_en_i,

  // Fetch enable pulse from the system and its sticky copy
  input  logic fetch_enable_i,

  // Busy levels of the core's sub units
  input  logic if_busy_i,
  input  logic ctrl_busy_i,
  input  logic lsu_busy_i,
  input  logic apu_busy_i,

  // Wake level from the wake detector
  input  logic wake_from_sleep_i,

  // Gated clock for the rest of the core
  output logic clk_gated_o,

  // Sticky fetch enable for the controller
  output logic fetch_enable_o,

  // Core sleep level for the system
  output logic core_sleep_o
);

  // Sticky fetch enable, set by the first pulse and cleared only by reset
  logic fetch_enable_q;
  logic fetch_enable_d;

  // Registered OR of the busy inputs
  // Keeps the clock running for one more edge after the last unit goes idle
  logic core_busy_q;
  logic core_busy_d;

  // Final enable into the clock gate
  logic clock_en;

  ////////////////////////////////////////////////////////////////////////////
  // Sleep control
  ////////////////////////////////////////////////////////////////////////////

  // Once a pulse has been seen the fetch enable stays set
  assign fetch_enable_d = fetch_enable_i | fetch_enable_q;

  // The core needs its clock while any unit still has work in flight
  assign core_busy_d = if_busy_i | ctrl_busy_i | lsu_busy_i | apu_busy_i;

  always_ff @(posedge clk_ungated_i, negedge rst_n) begin
    if (!rst_n) begin
      fetch_enable_q <= 1'b0;
      core_busy_q    <= 1'b0;
    end else begin
      fetch_enable_q <= fetch_enable_d;
      core_busy_q    <= core_busy_d;
    end
  end

  // The clock runs only after fetch is enabled, and then while busy or
  // while a wake is pending
  assign clock_en = fetch_enable_q & (wake_from_sleep_i | core_busy_q);

  // Sleep is the state in which fetch is enabled but the clock is held off
  assign core_sleep_o = fetch_enable_q & ~clock_en;

  assign fetch_enable_o = fetch_enable_q;

  // Main clock gate of the core
  pm_clock_gate core_clock_gate_inst (
    .clk_i        (clk_ungated_i),
    .en_i         (clock_en),
    .scan_cg_en_i (scan_cg_en_i),
    .clk_o        (clk_gated_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Without a fetch enable pulse on an earlier edge the clock stays off
  a_no_clock_before_fetch : assert property (
    @(posedge clk_ungated_i) disable iff (!rst_n)
    (!$past(fetch_enable_i) && !$past(fetch_enable_q)) |-> !clock_en
  );

  // Sleep and a running clock exclude each other
  a_sleep_gates_clock : assert property (
    @(posedge clk_ungated_i) disable iff (!rst_n)
    core_sleep_o |-> !clock_en
  );

  // While asleep and with no unit reporting new work nothing in this block
  // changes state
  // A unit that does report work ends sleep through the busy register
  a_state_frozen_in_sleep : assert property (
    @(posedge clk_ungated_i) disable iff (!rst_n)
    (core_sleep_o && !core_busy_d) |->
      (fetch_enable_q == fetch_enable_d) && (core_busy_q == core_busy_d)
  );

  // Sleep is entered only after an edge on which every unit was idle
  a_idle_before_sleep : assert property (
    @(posedge clk_ungated_i) disable iff (!rst_n)
    $rose(core_sleep_o) |-> $past(!if_busy_i && !ctrl_busy_i && !lsu_busy_i && !apu_busy_i)
  );

endmodule

// ==== source/pm_sleep_stats.sv ====
module pm_sleep_stats #(
  parameter int STAT_WIDTH = pm_cfg_pkg::PM_STAT_WIDTH
) (
  // Free running clock and asynchronous reset
  input  logic                       clk_ungated_i,
  input  logic                       rst_n,

  // Sleep level and the current wake cause
  input  logic                       core_sleep_i,
  input  pm_status_pkg::wake_cause_e wake_cause_i,

  // Statistics for software
  output logic [STAT_WIDTH-1:0]      sleep_cycles_o,
  output logic [STAT_WIDTH-1:0]      sleep_entries_o,
  output pm_status_pkg::wake_cause_e last_wake_cause_o
);

  import pm_status_pkg::*;

  // Saturation value of both counters
  localparam logic [STAT_WIDTH-1:0] STAT_MAX = '1;

  // Sleep level one edge ago, used to find entry and exit
  logic                  core_sleep_q;
  logic                  sleep_entry;
  logic                  sleep_exit;

  logic [STAT_WIDTH-1:0] sleep_cycles_q;
  logic [STAT_WIDTH-1:0] sleep_entries_q;
  wake_cause_e           last_wake_cause_q;

  // First edge with the core asleep
  assign sleep_entry = core_sleep_i & ~core_sleep_q;

  // First edge with the core awake again
  assign sleep_exit  = ~core_sleep_i & core_sleep_q;

  ////////////////////////////////////////////////////////////////////////////
  // Counters and wake cause
  ////////////////////////////////////////////////////////////////////////////

  // This block runs on the free clock since the gated clock stops in sleep
  always_ff @(posedge clk_ungated_i, negedge rst_n) begin
    if (!rst_n) begin
      core_sleep_q      <= 1'b0;
      sleep_cycles_q    <= '0;
      sleep_entries_q   <= '0;
      last_wake_cause_q <= WAKE_NONE;
    end else begin
      core_sleep_q <= core_sleep_i;
      // Every edge spent asleep counts, up to the saturation value
      if (core_sleep_i && (sleep_cycles_q != STAT_MAX)) begin
        sleep_cycles_q <= sleep_cycles_q + STAT_WIDTH'(1);
      end
      if (sleep_entry && (sleep_entries_q != STAT_MAX)) begin
        sleep_entries_q <= sleep_entries_q + STAT_WIDTH'(1);
      end
      // The wake detector still holds the cause on the exit edge
      if (sleep_exit) begin
        last_wake_cause_q <= wake_cause_i;
      end
    end
  end

  assign sleep_cycles_o    = sleep_cycles_q;
  assign sleep_entries_o   = sleep_entries_q;
  assign last_wake_cause_o = last_wake_cause_q;

  // Each entry also counts as a sleep cycle, so entries never lead
  a_entries_le_cycles : assert property (
    @(posedge clk_ungated_i) disable iff (!rst_n)
    sleep_entries_q <= sleep_cycles_q
  );

endmodule

// ==== source/pm_top.sv ====
module pm_top #(
  parameter int NUM_IRQ    = pm_cfg_pkg::PM_NUM_IRQ,
  parameter int STAT_WIDTH = pm_cfg_pkg::PM_STAT_WIDTH
) (
  // Free running clock and asynchronous reset
  input  logic                       clk_ungated_i,
  input  logic                       rst_n,

  // Scan override for the clock gate
  input  logic                       scan_cg_en_i,

  // Fetch enable pulse and its sticky copy
  input  logic                       fetch_enable_i,
  output logic                       fetch_enable_o,

  // Busy levels of the sub units
  input  logic                       if_busy_i,
  input  logic                       ctrl_busy_i,
  input  logic                       lsu_busy_i,
  input  logic                       apu_busy_i,

  // Wake sources
  input  logic [NUM_IRQ-1:0]         irq_i,
  input  logic [NUM_IRQ-1:0]         irq_enable_i,
  input  logic                       debug_req_i,

  // Clock and sleep outputs
  output logic                       clk_gated_o,
  output logic                       core_sleep_o,

  // Sleep statistics
  output logic [STAT_WIDTH-1:0]      sleep_cycles_o,
  output logic [STAT_WIDTH-1:0]      sleep_entries_o,
  output pm_status_pkg::wake_cause_e last_wake_cause_o
);

  import pm_status_pkg::*;

  // Wake level and its cause, shared by the sleep unit and the statistics
  logic        wake_level;
  wake_cause_e wake_cause;

  // Sleep level, also driven out of the subsystem
  logic        core_sleep;

  pm_wake_detect #(.NUM_IRQ(NUM_IRQ)) wake_detect_inst (
    .clk_ungated_i (clk_ungated_i),
    .rst_n         (rst_n),
    .irq_i         (irq_i),
    .irq_enable_i  (irq_enable_i),
    .debug_req_i   (debug_req_i),
    .wake_o        (wake_level),
    .wake_cause_o  (wake_cause)
  );

  pm_sleep_unit sleep_unit_inst (
    .clk_ungated_i     (clk_ungated_i),
    .rst_n             (rst_n),
    .scan_cg_en_i      (scan_cg_en_i),
    .fetch_enable_i    (fetch_enable_i),
    .if_busy_i         (if_busy_i),
    .ctrl_busy_i       (ctrl_busy_i),
    .lsu_busy_i        (lsu_busy_i),
    .apu_busy_i        (apu_busy_i),
    .wake_from_sleep_i (wake_level),
    .clk_gated_o       (clk_gated_o),
    .fetch_enable_o    (fetch_enable_o),
    .core_sleep_o      (core_sleep)
  );

  pm_sleep_stats #(.STAT_WIDTH(STAT_WIDTH)) sleep_stats_inst (
    .clk_ungated_i     (clk_ungated_i),
    .rst_n             (rst_n),
    .core_sleep_i      (core_sleep),
    .wake_cause_i      (wake_cause),
    .sleep_cycles_o    (sleep_cycles_o),
    .sleep_entries_o   (sleep_entries_o),
    .last_wake_cause_o (last_wake_cause_o)
  );

  assign core_sleep_o = core_sleep;

endmodule

// ==== testbench/tb_pm_top.sv ====
module tb_pm_top;

  timeunit 1ns;
  timeprecision 1ps;

  import pm_status_pkg::*;

  localparam int NUM_IRQ      = pm_cfg_pkg::PM_NUM_IRQ;
  localparam int STAT_WIDTH   = pm_cfg_pkg::PM_STAT_WIDTH;
  localparam int STAT_MAX     = (1 << STAT_WIDTH) - 1;
  localparam int HALF_PERIOD  = 50;
  // Outputs are sampled this long after a rising edge, just before the falling one
  localparam int CHECK_DELAY  = 40;
  localparam int GATE_TIMEOUT = 20;
  localparam int MAX_LINES    = 200;

  logic                  clk_ungated_i;
  logic                  rst_n;
  logic                  scan_cg_en_i;
  logic                  fetch_enable_i;
  logic                  if_busy_i;
  logic                  ctrl_busy_i;
  logic                  lsu_busy_i;
  logic                  apu_busy_i;
  logic [NUM_IRQ-1:0]    irq_i;
  logic [NUM_IRQ-1:0]    irq_enable_i;
  logic                  debug_req_i;
  logic                  clk_gated_o;
  logic                  fetch_enable_o;
  logic                  core_sleep_o;
  logic [STAT_WIDTH-1:0] sleep_cycles_o;
  logic [STAT_WIDTH-1:0] sleep_entries_o;
  wake_cause_e           last_wake_cause_o;

  int checks;
  int mismatches;
  int other_errors;
  int gated_edges;

  pm_top #(.NUM_IRQ(NUM_IRQ), .STAT_WIDTH(STAT_WIDTH)) pm_top_inst (.*);

  always #(HALF_PERIOD) clk_ungated_i = ~clk_ungated_i;

  // Rising edges of the gated clock since the start of the run, reset included
  always @(posedge clk_gated_o) begin
    gated_edges <= gated_edges + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the sleep cycle count
  ////////////////////////////////////////////////////////////////////////////

  // Tracks the sticky fetch enable, the registered busy summary and the
  // interrupt synchronizer, so the random idle gaps are counted too
  logic               model_fetch;
  logic               model_busy;
  logic [NUM_IRQ-1:0] model_sync [PM_SYNC_STAGES];
  int                 model_cycles;

  always @(posedge clk_ungated_i, negedge rst_n) begin : model_update
    logic model_wake;
    logic model_clock_en;
    logic model_sleep;
    if (!rst_n) begin
      model_fetch  <= 1'b0;
      model_busy   <= 1'b0;
      model_cycles <= 0;
      for (int i = 0; i < PM_SYNC_STAGES; i++) begin
        model_sync[i] <= '0;
      end
    end else begin
      // Sleep level as it stands just before this edge
      model_wake     = ((model_sync[PM_SYNC_STAGES-1] & irq_enable_i) != '0) || debug_req_i;
      model_clock_en = model_fetch && (model_wake || model_busy);
      model_sleep    = model_fetch && !model_clock_en;
      if (model_sleep && model_cycles < STAT_MAX) begin
        model_cycles <= model_cycles + 1;
      end
      model_fetch   <= model_fetch | fetch_enable_i;
      model_busy    <= if_busy_i | ctrl_busy_i | lsu_busy_i | apu_busy_i;
      model_sync[0] <= irq_i;
      for (int i = 1; i < PM_SYNC_STAGES; i++) begin
        model_sync[i] <= model_sync[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string test_name, input string signal_name,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH %s %s expected %0d actual %0d", test_name, signal_name,
               expected, actual);
    end
  endtask

  task automatic drive_inputs(input logic fe, input logic [3:0] busy, input int irq,
                              input int irq_en, input logic dbg, input logic scan);
    fetch_enable_i = fe;
    if_busy_i      = busy[3];
    ctrl_busy_i    = busy[2];
    lsu_busy_i     = busy[1];
    apu_busy_i     = busy[0];
    irq_i          = NUM_IRQ'(irq);
    irq_enable_i   = NUM_IRQ'(irq_en);
    debug_req_i    = dbg;
    scan_cg_en_i   = scan;
  endtask

  // Returns at once if the step already produced a gated edge
  task automatic wait_gated_edge(input string test_name, input int start_count);
    int waited;
    waited = 0;
    while (gated_edges == start_count && waited < GATE_TIMEOUT) begin
      @(negedge clk_ungated_i);
      waited++;
    end
    if (gated_edges == start_count) begin
      other_errors++;
      $display("Step %s: gated clock did not toggle within %0d cycles", test_name,
               GATE_TIMEOUT);
    end else if (waited > 0) begin
      other_errors++;
      $display("Step %s: gated clock toggled only after the step had ended", test_name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int    fd;
    int    fields;
    int    lines_read;
    int    start_edges;
    int    gap_cycles;
    string line;
    string test_name;
    int    gap_flag, fe, if_b, ctrl_b, lsu_b, apu_b, irq, irq_en, dbg, scan, hold;
    int    exp_fe, exp_sleep, exp_entries, exp_cause, exp_gate;
    checks        = 0;
    mismatches    = 0;
    other_errors  = 0;
    gated_edges   = 0;
    lines_read    = 0;
    clk_ungated_i = 1'b0;
    rst_n         = 1'b0;
    drive_inputs(1'b0, 4'b0000, 0, 0, 1'b0, 1'b0);
    void'($urandom(6));

    // Reset for five cycles, with everything inactive while it is held
    repeat (5) @(negedge clk_ungated_i);
    check_value("reset", "gated clock edges", 0, gated_edges);
    check_value("reset", "fetch_enable_o", 0, fetch_enable_o);
    check_value("reset", "core_sleep_o", 0, core_sleep_o);
    check_value("reset", "sleep_cycles_o", 0, sleep_cycles_o);
    check_value("reset", "sleep_entries_o", 0, sleep_entries_o);
    check_value("reset", "last_wake_cause_o", WAKE_NONE, last_wake_cause_o);
    rst_n = 1'b1;

    fd = $fopen("testbench/pm_cases.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the cases file testbench/pm_cases.txt");
    end else begin
      while (lines_read < MAX_LINES && $fgets(line, fd) != 0) begin
        lines_read++;
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        fields = $sscanf(line, "%s %d %d %d %d %d %d %h %h %d %d %d %d %d %d %d %d",
                         test_name, gap_flag, fe, if_b, ctrl_b, lsu_b, apu_b, irq, irq_en,
                         dbg, scan, hold, exp_fe, exp_sleep, exp_entries, exp_cause,
                         exp_gate);
        if (fields != 17) begin
          other_errors++;
          $display("Line %0d of the cases file could not be parsed", lines_read);
          continue;
        end
        // Idle gap of random length with every input low
        if (gap_flag != 0) begin
          gap_cycles = $urandom % 4;
          drive_inputs(1'b0, 4'b0000, 0, 0, 1'b0, 1'b0);
          repeat (gap_cycles) @(negedge clk_ungated_i);
        end
        drive_inputs(fe[0], {if_b[0], ctrl_b[0], lsu_b[0], apu_b[0]}, irq, irq_en,
                     dbg[0], scan[0]);
        start_edges = gated_edges;
        repeat (hold) @(posedge clk_ungated_i);
        #(CHECK_DELAY);
        check_value(test_name, "fetch_enable_o", exp_fe, fetch_enable_o);
        check_value(test_name, "core_sleep_o", exp_sleep, core_sleep_o);
        check_value(test_name, "sleep_entries_o", exp_entries, sleep_entries_o);
        check_value(test_name, "last_wake_cause_o", exp_cause, last_wake_cause_o);
        check_value(test_name, "sleep_cycles_o", model_cycles, sleep_cycles_o);
        if (exp_gate == 1) begin
          wait_gated_edge(test_name, start_edges);
        end else if (gated_edges != start_edges) begin
          other_errors++;
          $display("Step %s: gated clock toggled while it should have been stopped",
                   test_name);
        end
        @(negedge clk_ungated_i);
      end
      $fclose(fd);

      // Debug request and enabled interrupt present on the same edge
      // The line first passes the synchronizer while its enable is still clear
      drive_inputs(1'b0, 4'b0000, 1, 0, 1'b0, 1'b0);
      repeat (PM_SYNC_STAGES) @(posedge clk_ungated_i);
      #(CHECK_DELAY);
      check_value("debug_priority", "core_sleep_o", 1, core_sleep_o);
      @(negedge clk_ungated_i);
      drive_inputs(1'b0, 4'b0000, 1, 1, 1'b1, 1'b0);
      @(posedge clk_ungated_i);
      #(CHECK_DELAY);
      check_value("debug_priority", "last_wake_cause_o", WAKE_DEBUG, last_wake_cause_o);
    end

    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
             other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
source/pm_cfg_pkg.sv
source/pm_status_pkg.sv
source/pm_wake_detect.sv
source/pm_clock_gate.sv
source/pm_sleep_unit.sv
source/pm_sleep_stats.sv
source/pm_top.sv
testbench/tb_pm_top.sv

// ==== testbench/pm_cases.txt ====
# Columns: name gap fe if_busy ctrl_busy lsu_busy apu_busy irq(hex) irq_en(hex) debug scan hold
# then expected: fetch_enable_o core_sleep_o sleep_entries_o last_wake_cause_o gate
# gate is 1 when the gated clock must toggle in the step and 0 when it must stay still
reset_idle       0 0 0 0 0 0 0 0 0 0   3  0 0 0 0 0
fetch_pulse      0 1 0 0 0 0 0 0 0 0   1  1 1 0 0 0
sleep_hold       1 0 0 0 0 0 0 0 0 0   3  1 1 1 0 0
busy_run         1 0 1 0 0 0 0 0 0 0   4  1 0 1 0 1
busy_mix         0 0 0 0 1 1 0 0 0 0   2  1 0 1 0 1
busy_drop        0 0 0 0 0 0 0 0 0 0   1  1 1 1 0 1
sleep_again      1 0 0 0 0 0 0 0 0 0   2  1 1 2 0 0
irq_rise         1 0 0 0 0 0 1 f 0 0   1  1 1 2 0 0
irq_wake         0 0 0 0 0 0 1 f 0 0   1  1 0 2 0 0
irq_awake        0 0 0 0 0 0 1 f 0 0   2  1 0 2 1 1
irq_drop         0 0 0 0 0 0 0 f 0 0   2  1 1 2 1 1
irq_masked       1 0 0 0 0 0 2 d 0 0   4  1 1 3 1 0
irq_flush        1 0 0 0 0 0 0 0 0 0   3  1 1 3 1 0
debug_wake       1 0 0 0 0 0 1 1 1 0   1  1 0 3 2 1
debug_hold       0 0 0 0 0 0 1 1 1 0   3  1 0 3 2 1
debug_release    0 0 0 0 0 0 0 1 0 0   3  1 1 4 2 1
scan_sleep       1 0 0 0 0 0 0 0 0 1   3  1 1 4 2 1
scan_off         0 0 0 0 0 0 0 0 0 0   2  1 1 4 2 0
long_sleep       1 0 0 0 0 0 0 0 0 0 250  1 1 4 2 0
final_busy_wake  0 0 0 1 0 0 0 0 0 0   2  1 0 4 0 1
